//--- Bender.yml
package:
  name: id_stage

sources:
  - hdl/id_pkg.sv
  - hdl/rs_slot_if.sv
  - hdl/decoder.sv
  - hdl/dispatch.sv
  - hdl/rs_entry.sv
  - hdl/issue_select.sv
  - hdl/id_stage.sv
  - target: test
    files:
      - dv/tb_id_stage.sv

//--- all.f
hdl/id_pkg.sv
hdl/rs_slot_if.sv
hdl/decoder.sv
hdl/dispatch.sv
hdl/rs_entry.sv
hdl/issue_select.sv
hdl/id_stage.sv
dv/tb_id_stage.sv

//--- dv/tb_id_stage.sv
/*
 * testbench for the dispatch and issue slice
 * drives instructions and CDB strobes, checks every issue against a reference queue
 */
`default_nettype none

module tb_id_stage;

    import id_pkg::*;

    localparam int depth   = 64;
    localparam int not_yet = 1000000;

    logic                    clock;
    logic                    reset;
    logic                    dispatch_valid;
    inst_t                   inst;
    logic [xlen-1:0]         pc;
    logic [rob_tag_bits-1:0] rob_tag;
    logic [xlen-1:0]         src1_value;
    logic [rob_tag_bits-1:0] src1_tag;
    logic                    src1_ready;
    logic [xlen-1:0]         src2_value;
    logic [rob_tag_bits-1:0] src2_tag;
    logic                    src2_ready;
    logic                    cdb_valid;
    logic [rob_tag_bits-1:0] cdb_tag;
    logic [xlen-1:0]         cdb_value;
    logic                    full;
    logic                    illegal;
    logic                    issue_valid;
    logic [xlen-1:0]         issue_opa;
    logic [xlen-1:0]         issue_opb;
    alu_func_t               issue_alu_func;
    logic [rob_tag_bits-1:0] issue_rob_tag;

    // reference queue, one slot per expected issue
    string                   exp_name  [depth];
    logic [xlen-1:0]         exp_opa   [depth];
    logic [xlen-1:0]         exp_opb   [depth];
    alu_func_t               exp_func  [depth];
    logic [rob_tag_bits-1:0] exp_tag   [depth];
    int                      exp_cycle [depth];
    int                      rd_ptr = 0;
    int                      wr_ptr = 0;
    int                      cycle  = 0;
    int                      errors = 0;
    int                      seed;
    logic                    exp_illegal;
    string                   test_name;

    id_stage DUT (.*);

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    always @(posedge clock) cycle <= cycle + 1;

    // head leaves the queue once its issue has been checked
    always @(negedge clock) begin
        if (!reset && issue_valid && (rd_ptr != wr_ptr)) begin
            rd_ptr <= rd_ptr + 1;
        end
    end

    task automatic report_value(input string name, input string field,
                                input logic [31:0] expected, input logic [31:0] actual);
        errors++;
        $display("FAIL %s %s expected %0h actual %0h", name, field, expected, actual);
    endtask

    //////////////////////////////////////////////////
    // checking assertions
    issue_expected: assert property (
        @(negedge clock) disable iff (reset) issue_valid |-> (rd_ptr != wr_ptr)
    ) else begin
        errors++;
        $display("issue of rob tag %0d while no issue was expected", $sampled(issue_rob_tag));
    end

    opa_match: assert property (
        @(negedge clock) disable iff (reset)
        issue_valid && (rd_ptr != wr_ptr) |-> issue_opa == exp_opa[rd_ptr]
    ) else report_value(exp_name[$sampled(rd_ptr)], "opa", exp_opa[$sampled(rd_ptr)],
                        $sampled(issue_opa));

    opb_match: assert property (
        @(negedge clock) disable iff (reset)
        issue_valid && (rd_ptr != wr_ptr) |-> issue_opb == exp_opb[rd_ptr]
    ) else report_value(exp_name[$sampled(rd_ptr)], "opb", exp_opb[$sampled(rd_ptr)],
                        $sampled(issue_opb));

    func_match: assert property (
        @(negedge clock) disable iff (reset)
        issue_valid && (rd_ptr != wr_ptr) |-> issue_alu_func == exp_func[rd_ptr]
    ) else report_value(exp_name[$sampled(rd_ptr)], "alu_func", exp_func[$sampled(rd_ptr)],
                        $sampled(issue_alu_func));

    tag_match: assert property (
        @(negedge clock) disable iff (reset)
        issue_valid && (rd_ptr != wr_ptr) |-> issue_rob_tag == exp_tag[rd_ptr]
    ) else report_value(exp_name[$sampled(rd_ptr)], "rob_tag", exp_tag[$sampled(rd_ptr)],
                        $sampled(issue_rob_tag));

    cycle_match: assert property (
        @(negedge clock) disable iff (reset)
        issue_valid && (rd_ptr != wr_ptr) |-> cycle == exp_cycle[rd_ptr]
    ) else begin
        errors++;
        $display("FAIL %s issue cycle expected %0d actual %0d", exp_name[$sampled(rd_ptr)],
                 exp_cycle[$sampled(rd_ptr)], $sampled(cycle));
    end

    // illegal is combinational in the dispatch cycle
    illegal_match: assert property (
        @(posedge clock) disable iff (reset) illegal == (dispatch_valid && exp_illegal)
    ) else begin
        errors++;
        $display("FAIL %s illegal expected %0b actual %0b", test_name,
                 $sampled(dispatch_valid && exp_illegal), $sampled(illegal));
    end

    //////////////////////////////////////////////////
    // encoders and operand helpers
    function automatic inst_t r_word(input logic [6:0] f7, input logic [2:0] f3);
        return {f7, 5'd3, 5'd2, f3, 5'd1, op_reg};
    endfunction

    function automatic inst_t i_word(input logic [11:0] imm, input logic [2:0] f3,
                                     input logic [6:0] opcode);
        return {imm, 5'd2, f3, 5'd1, opcode};
    endfunction

    function automatic inst_t u_word(input logic [19:0] upper, input logic [6:0] opcode);
        return {upper, 5'd1, opcode};
    endfunction

    function automatic operand_t ready_op(input logic [xlen-1:0] value);
        return '{value: value, tag: '0, ready: 1'b1};
    endfunction

    function automatic operand_t pending_op(input logic [rob_tag_bits-1:0] tag);
        return '{value: '0, tag: tag, ready: 1'b0};
    endfunction

    //////////////////////////////////////////////////
    // stimulus, always entered 1 unit after a rising edge
    task automatic push_expected(input string name, input logic [31:0] opa,
                                 input logic [31:0] opb, input alu_func_t func,
                                 input logic [4:0] tag, input int when, output int idx);
        idx             = wr_ptr;
        exp_name[idx]   = name;
        exp_opa[idx]    = opa;
        exp_opb[idx]    = opb;
        exp_func[idx]   = func;
        exp_tag[idx]    = tag;
        exp_cycle[idx]  = when;
        wr_ptr          = wr_ptr + 1;
    endtask

    task automatic drive_dispatch(input inst_t word, input logic [31:0] pc_v,
                                  input logic [4:0] tag, input operand_t s1,
                                  input operand_t s2, input logic bad);
        dispatch_valid = 1'b1;
        inst           = word;
        pc             = pc_v;
        rob_tag        = tag;
        src1_value     = s1.value;
        src1_tag       = s1.tag;
        src1_ready     = s1.ready;
        src2_value     = s2.value;
        src2_tag       = s2.tag;
        src2_ready     = s2.ready;
        exp_illegal    = bad;
        @(posedge clock);
        #1;
        dispatch_valid = 1'b0;
        exp_illegal    = 1'b0;
    endtask

    task automatic drive_cdb(input logic [4:0] tag, input logic [31:0] value);
        cdb_valid = 1'b1;
        cdb_tag   = tag;
        cdb_value = value;
        @(posedge clock);
        #1;
        cdb_valid = 1'b0;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clock);
            #1;
        end
    endtask

    task automatic check_full(input string name, input logic expected);
        assert (full == expected) else begin
            errors++;
            $display("FAIL %s full expected %0b actual %0b", name, expected, full);
        end
    endtask

    task automatic wait_drained(input string name);
        int n;
        n = 0;
        while ((rd_ptr != wr_ptr) && (n < 40)) begin
            @(posedge clock);
            #1;
            n++;
        end
        if (rd_ptr != wr_ptr) begin
            errors++;
            $display("timeout in %s, %0d expected issues never came", name, wr_ptr - rd_ptr);
        end
    endtask

    task automatic wait_full_low(input string name);
        int n;
        n = 0;
        while (full && (n < 20)) begin
            @(posedge clock);
            #1;
            n++;
        end
        if (full) begin
            errors++;
            $display("timeout in %s, full never fell after the wakeup", name);
        end
    endtask

    //////////////////////////////////////////////////
    // tests
    task automatic test_ready_ops();
        logic [6:0]  f7 [10];
        logic [2:0]  f3 [10];
        alu_func_t   func [10];
        logic [31:0] a;
        logic [31:0] b;
        int          idx;
        f7   = '{7'h00, 7'h20, 7'h00, 7'h00, 7'h00, 7'h20, 7'h01, 7'h01, 7'h01, 7'h01};
        f3   = '{3'd0, 3'd0, 3'd2, 3'd1, 3'd5, 3'd5, 3'd0, 3'd1, 3'd2, 3'd3};
        func = '{alu_add, alu_sub, alu_slt, alu_sll, alu_srl, alu_sra,
                 alu_mul, alu_mulh, alu_mulhsu, alu_mulhu};
        test_name = "ready_ops";
        for (int i = 0; i < 10; i++) begin
            a = $random(seed);
            b = $random(seed);
            push_expected($sformatf("ready_ops %s", func[i].name()), a, b, func[i], 5'(i),
                          cycle + 2, idx);
            drive_dispatch(r_word(f7[i], f3[i]), 32'h1000 + 4 * i, 5'(i), ready_op(a),
                           ready_op(b), 1'b0);
        end
        wait_drained(test_name);
    endtask

    task automatic test_immediates();
        logic [31:0] a;
        logic [11:0] imm;
        logic [19:0] upper;
        int          idx;
        test_name = "immediates";
        a     = $random(seed);
        upper = $random(seed);
        // negative immediate checks the sign extension
        imm = 12'hf9c;
        push_expected("addi", a, {{20{imm[11]}}, imm}, alu_add, 5'd10, cycle + 2, idx);
        drive_dispatch(i_word(imm, 3'b000, op_imm), 32'h2000, 5'd10, ready_op(a),
                       pending_op(5'd6), 1'b0);
        imm = {7'b0100000, 5'd13};
        push_expected("srai", a, {{20{imm[11]}}, imm}, alu_sra, 5'd11, cycle + 2, idx);
        drive_dispatch(i_word(imm, 3'b101, op_imm), 32'h2004, 5'd11, ready_op(a),
                       pending_op(5'd6), 1'b0);
        // pending sources are ignored when the opcode picks zero or pc
        push_expected("lui", 32'h0, {upper, 12'h0}, alu_add, 5'd12, cycle + 2, idx);
        drive_dispatch(u_word(upper, op_lui), 32'h2008, 5'd12, pending_op(5'd4),
                       pending_op(5'd5), 1'b0);
        push_expected("auipc", 32'h8000_0040, {upper, 12'h0}, alu_add, 5'd13, cycle + 2, idx);
        drive_dispatch(u_word(upper, op_auipc), 32'h8000_0040, 5'd13, pending_op(5'd4),
                       pending_op(5'd5), 1'b0);
        wait_drained(test_name);
    endtask

    task automatic test_wakeup();
        logic [31:0] a;
        logic [31:0] v1;
        logic [31:0] v2;
        logic [31:0] v3;
        int          first;
        int          second;
        test_name = "wakeup";
        a  = $random(seed);
        v1 = $random(seed);
        v2 = $random(seed);
        v3 = $random(seed);
        push_expected("wakeup one", a, v1, alu_add, 5'd16, not_yet, first);
        drive_dispatch(r_word(7'h00, 3'b000), 32'h3000, 5'd16, ready_op(a),
                       pending_op(5'd7), 1'b0);
        push_expected("wakeup both", v2, v3, alu_xor, 5'd17, not_yet, second);
        drive_dispatch(r_word(7'h00, 3'b100), 32'h3004, 5'd17, pending_op(5'd8),
                       pending_op(5'd9), 1'b0);
        // a foreign tag leaves both waiting
        drive_cdb(5'd11, $random(seed));
        idle(3);
        exp_cycle[first] = cycle + 2;
        drive_cdb(5'd7, v1);
        drive_cdb(5'd8, v2);
        exp_cycle[second] = cycle + 2;
        drive_cdb(5'd9, v3);
        wait_drained(test_name);
    endtask

    task automatic test_bypass();
        logic [31:0] a;
        logic [31:0] v;
        int          idx;
        test_name = "bypass";
        a = $random(seed);
        v = $random(seed);
        push_expected("bypass", a, v, alu_sub, 5'd18, cycle + 2, idx);
        cdb_valid = 1'b1;
        cdb_tag   = 5'd12;
        cdb_value = v;
        drive_dispatch(r_word(7'h20, 3'b000), 32'h4000, 5'd18, ready_op(a),
                       pending_op(5'd12), 1'b0);
        cdb_valid = 1'b0;
        wait_drained(test_name);
    endtask

    task automatic test_illegal();
        test_name = "illegal";
        // pending sources would hold any loaded entry busy, so four of them fill the station
        drive_dispatch(i_word(12'h010, 3'b010, 7'b0000011), 32'h5000, 5'd19,
                       pending_op(5'd30), pending_op(5'd30), 1'b1);
        drive_dispatch({7'h00, 5'd3, 5'd2, 3'b000, 5'd8, 7'b1100011}, 32'h5004, 5'd19,
                       pending_op(5'd30), pending_op(5'd30), 1'b1);
        drive_dispatch(32'h0000_007f, 32'h5008, 5'd19, pending_op(5'd30),
                       pending_op(5'd30), 1'b1);
        // divide sits outside the kept multiply group
        drive_dispatch(r_word(7'h01, 3'b100), 32'h500c, 5'd19, pending_op(5'd30),
                       pending_op(5'd30), 1'b1);
        idle(3);
        check_full(test_name, 1'b0);
    endtask

    task automatic test_full();
        logic [31:0] v;
        logic [31:0] b [4];
        int          idx [4];
        int          c;
        test_name = "full";
        v = $random(seed);
        for (int i = 0; i < 4; i++) begin
            b[i] = $random(seed);
            push_expected($sformatf("full entry %0d", i), v, b[i], alu_add, 5'(20 + i),
                          not_yet, idx[i]);
            check_full(test_name, 1'b0);
            drive_dispatch(r_word(7'h00, 3'b000), 32'h6000 + 4 * i, 5'(20 + i),
                           pending_op(5'd21), ready_op(b[i]), 1'b0);
        end
        check_full(test_name, 1'b1);
        // one strobe wakes all four, entry order one per cycle
        c = cycle;
        for (int i = 0; i < 4; i++) begin
            exp_cycle[idx[i]] = c + 2 + i;
        end
        drive_cdb(5'd21, v);
        wait_full_low(test_name);
        wait_drained(test_name);
    endtask

    initial begin
        seed           = 98;
        test_name      = "reset";
        exp_illegal    = 1'b0;
        reset          = 1'b1;
        dispatch_valid = 1'b0;
        inst           = '0;
        pc             = '0;
        rob_tag        = '0;
        src1_value     = '0;
        src1_tag       = '0;
        src1_ready     = 1'b0;
        src2_value     = '0;
        src2_tag       = '0;
        src2_ready     = 1'b0;
        cdb_valid      = 1'b0;
        cdb_tag        = '0;
        cdb_value      = '0;
        repeat (3) @(posedge clock);
        #1;
        reset = 1'b0;
        check_full("reset", 1'b0);

        test_ready_ops();
        test_immediates();
        test_wakeup();
        test_bypass();
        test_illegal();
        test_full();
        idle(4);

        $display("issues checked %0d of %0d expected, errors %0d", rd_ptr, wr_ptr, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/decoder.sv
/*
 * combinational RV32IM decoder for the ALU subset
 * anything outside LUI, AUIPC, OP-IMM and OP flags illegal when valid
 */
`default_nettype none

module decoder (
    input  id_pkg::inst_t       inst,
    input  logic                valid,
    output id_pkg::alu_func_t   alu_func,
    output id_pkg::opa_select_t opa_select,
    output id_pkg::opb_select_t opb_select,
    output logic                illegal
);

    import id_pkg::*;

    logic [16:0] key;
    logic        legal;

    // funct7, funct3 and opcode side by side
    assign key = {inst[31:25], inst[14:12], inst[6:0]};

    always_comb begin
        alu_func   = alu_add;
        opa_select = opa_is_rs1;
        opb_select = opb_is_rs2;
        legal      = 1'b1;

        casez (key)
            {7'b???????, 3'b???, op_lui}: begin
                opa_select = opa_is_zero;
                opb_select = opb_is_u_imm;
            end
            {7'b???????, 3'b???, op_auipc}: begin
                opa_select = opa_is_pc;
                opb_select = opb_is_u_imm;
            end

            //////////////////////////////////////////////////
            // OP-IMM
            {7'b???????, 3'b000, op_imm}: opb_select = opb_is_i_imm;
            {7'b???????, 3'b010, op_imm}: begin
                opb_select = opb_is_i_imm;
                alu_func   = alu_slt;
            end
            {7'b???????, 3'b011, op_imm}: begin
                opb_select = opb_is_i_imm;
                alu_func   = alu_sltu;
            end
            {7'b???????, 3'b100, op_imm}: begin
                opb_select = opb_is_i_imm;
                alu_func   = alu_xor;
            end
            {7'b???????, 3'b110, op_imm}: begin
                opb_select = opb_is_i_imm;
                alu_func   = alu_or;
            end
            {7'b???????, 3'b111, op_imm}: begin
                opb_select = opb_is_i_imm;
                alu_func   = alu_and;
            end
            // shift amounts sit in the low immediate bits
            {funct7_base, 3'b001, op_imm}: begin
                opb_select = opb_is_i_imm;
                alu_func   = alu_sll;
            end
            {funct7_base, 3'b101, op_imm}: begin
                opb_select = opb_is_i_imm;
                alu_func   = alu_srl;
            end
            {funct7_alt, 3'b101, op_imm}: begin
                opb_select = opb_is_i_imm;
                alu_func   = alu_sra;
            end

            //////////////////////////////////////////////////
            // OP, register-register
            {funct7_base, 3'b000, op_reg}: alu_func = alu_add;
            {funct7_alt,  3'b000, op_reg}: alu_func = alu_sub;
            {funct7_base, 3'b001, op_reg}: alu_func = alu_sll;
            {funct7_base, 3'b010, op_reg}: alu_func = alu_slt;
            {funct7_base, 3'b011, op_reg}: alu_func = alu_sltu;
            {funct7_base, 3'b100, op_reg}: alu_func = alu_xor;
            {funct7_base, 3'b101, op_reg}: alu_func = alu_srl;
            {funct7_alt,  3'b101, op_reg}: alu_func = alu_sra;
            {funct7_base, 3'b110, op_reg}: alu_func = alu_or;
            {funct7_base, 3'b111, op_reg}: alu_func = alu_and;
            // multiply group, no divide
            {funct7_mul,  3'b000, op_reg}: alu_func = alu_mul;
            {funct7_mul,  3'b001, op_reg}: alu_func = alu_mulh;
            {funct7_mul,  3'b010, op_reg}: alu_func = alu_mulhsu;
            {funct7_mul,  3'b011, op_reg}: alu_func = alu_mulhu;

            default: legal = 1'b0;
        endcase
    end

    assign illegal = valid && !legal;

endmodule

`default_nettype wire

//--- hdl/dispatch.sv
/*
 * forms the station payload from a decoded instruction and its renamed sources
 * and writes it into the lowest free entry in the dispatch cycle
 */
`default_nettype none

module dispatch (
    input  logic                               clock,
    input  logic                               reset,
    input  logic                               dispatch_valid,
    input  id_pkg::inst_t                      inst,
    input  logic [id_pkg::xlen-1:0]            pc,
    input  logic [id_pkg::rob_tag_bits-1:0]    rob_tag,
    input  id_pkg::operand_t                   src1,
    input  id_pkg::operand_t                   src2,
    input  id_pkg::cdb_t                       cdb,
    rs_slot_if.disp                            slots [id_pkg::rs_entries],
    output logic                               illegal,
    output logic                               full
);

    import id_pkg::*;

    alu_func_t             alu_func;
    opa_select_t           opa_select;
    opb_select_t           opb_select;
    logic [xlen-1:0]       imm_i;
    logic [xlen-1:0]       imm_u;
    operand_t              opa;
    operand_t              opb;
    rs_payload_t           payload;
    logic [rs_entries-1:0] busy_vec;
    logic [rs_entries-1:0] free_vec;
    logic [rs_entries-1:0] load_vec;

    decoder decoder_0 (
        .inst       (inst),
        .valid      (dispatch_valid),
        .alu_func   (alu_func),
        .opa_select (opa_select),
        .opb_select (opb_select),
        .illegal    (illegal)
    );

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_u = {inst[31:12], 12'b0};

    //////////////////////////////////////////////////
    // operand forming, CDB bypass on register sources
    always_comb begin
        case (opa_select)
            opa_is_pc: opa = '{value: pc, tag: '0, ready: 1'b1};
            opa_is_zero: opa = '{value: '0, tag: '0, ready: 1'b1};
            default: opa = operand_wakeup(src1, cdb);
        endcase

        case (opb_select)
            opb_is_i_imm: opb = '{value: imm_i, tag: '0, ready: 1'b1};
            opb_is_u_imm: opb = '{value: imm_u, tag: '0, ready: 1'b1};
            default: opb = operand_wakeup(src2, cdb);
        endcase
    end

    assign payload = '{opa: opa, opb: opb, alu_func: alu_func, rob_tag: rob_tag};

    //////////////////////////////////////////////////
    // lowest free entry takes the instruction
    assign free_vec = ~busy_vec;
    assign load_vec = (dispatch_valid && !illegal) ? (free_vec & (~free_vec + 1'b1)) : '0;
    assign full     = &busy_vec;

    for (genvar i = 0; i < rs_entries; i++) begin : g_slot
        assign slots[i].load    = load_vec[i];
        assign slots[i].payload = payload;
        assign busy_vec[i]      = slots[i].busy;
    end

    // the rename unit holds off while every entry is taken
    no_dispatch_when_full: assert property (
        @(posedge clock) disable iff (reset) dispatch_valid |-> !full
    );

endmodule

`default_nettype wire

//--- hdl/id_pkg.sv
/*
 * shared widths, RV32IM encodings and payload types for the dispatch/issue slice
 * imported by every module of the decode stage
 */
`default_nettype none

package id_pkg;

    localparam int xlen         = 32;
    localparam int rob_tag_bits = 5;
    localparam int rs_entries   = 4;

    // kept major opcodes
    localparam logic [6:0] op_lui   = 7'b0110111;
    localparam logic [6:0] op_auipc = 7'b0010111;
    localparam logic [6:0] op_imm   = 7'b0010011;
    localparam logic [6:0] op_reg   = 7'b0110011;

    // funct7 variants
    localparam logic [6:0] funct7_base = 7'b0000000;
    localparam logic [6:0] funct7_alt  = 7'b0100000;
    localparam logic [6:0] funct7_mul  = 7'b0000001;

    typedef logic [31:0] inst_t;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_slt, alu_sltu,
        alu_and, alu_or, alu_xor,
        alu_sll, alu_srl, alu_sra,
        alu_mul, alu_mulh, alu_mulhsu, alu_mulhu
    } alu_func_t;

    typedef enum logic [1:0] {
        opa_is_rs1, opa_is_pc, opa_is_zero
    } opa_select_t;

    typedef enum logic [1:0] {
        opb_is_rs2, opb_is_i_imm, opb_is_u_imm
    } opb_select_t;

    // tag is only meaningful while ready is low
    typedef struct packed {
        logic [xlen-1:0]         value;
        logic [rob_tag_bits-1:0] tag;
        logic                    ready;
    } operand_t;

    typedef struct packed {
        operand_t                opa;
        operand_t                opb;
        alu_func_t               alu_func;
        logic [rob_tag_bits-1:0] rob_tag;
    } rs_payload_t;

    typedef struct packed {
        logic                    valid;
        logic [rob_tag_bits-1:0] tag;
        logic [xlen-1:0]         value;
    } cdb_t;

    // capture a pending operand off the CDB on a tag match
    function automatic operand_t operand_wakeup(input operand_t op, input cdb_t cdb);
        operand_t result;
        result = op;
        if (!op.ready && cdb.valid && (cdb.tag == op.tag)) begin
            result.value = cdb.value;
            result.ready = 1'b1;
        end
        return result;
    endfunction

endpackage

`default_nettype wire

//--- hdl/id_stage.sv
/*
 * top of the out-of-order dispatch and issue slice
 * plain ports in, one dispatch unit, the station entries and issue select inside
 */
`default_nettype none

module id_stage (
    input  logic                            clock,
    input  logic                            reset,
    input  logic                            dispatch_valid,
    input  id_pkg::inst_t                   inst,
    input  logic [id_pkg::xlen-1:0]         pc,
    input  logic [id_pkg::rob_tag_bits-1:0] rob_tag,
    input  logic [id_pkg::xlen-1:0]         src1_value,
    input  logic [id_pkg::rob_tag_bits-1:0] src1_tag,
    input  logic                            src1_ready,
    input  logic [id_pkg::xlen-1:0]         src2_value,
    input  logic [id_pkg::rob_tag_bits-1:0] src2_tag,
    input  logic                            src2_ready,
    input  logic                            cdb_valid,
    input  logic [id_pkg::rob_tag_bits-1:0] cdb_tag,
    input  logic [id_pkg::xlen-1:0]         cdb_value,
    output logic                            full,
    output logic                            illegal,
    output logic                            issue_valid,
    output logic [id_pkg::xlen-1:0]         issue_opa,
    output logic [id_pkg::xlen-1:0]         issue_opb,
    output id_pkg::alu_func_t               issue_alu_func,
    output logic [id_pkg::rob_tag_bits-1:0] issue_rob_tag
);

    import id_pkg::*;

    operand_t src1;
    operand_t src2;
    cdb_t     cdb;

    assign src1 = '{value: src1_value, tag: src1_tag, ready: src1_ready};
    assign src2 = '{value: src2_value, tag: src2_tag, ready: src2_ready};
    assign cdb  = '{valid: cdb_valid, tag: cdb_tag, value: cdb_value};

    rs_slot_if slots [rs_entries] ();

    dispatch dispatch_0 (
        .clock          (clock),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .inst           (inst),
        .pc             (pc),
        .rob_tag        (rob_tag),
        .src1           (src1),
        .src2           (src2),
        .cdb            (cdb),
        .slots          (slots),
        .illegal        (illegal),
        .full           (full)
    );

    for (genvar i = 0; i < rs_entries; i++) begin : g_entry
        rs_entry rs_entry_i (
            .clock (clock),
            .reset (reset),
            .slot  (slots[i]),
            .cdb   (cdb)
        );
    end

    issue_select issue_select_0 (
        .clock          (clock),
        .reset          (reset),
        .slots          (slots),
        .issue_valid    (issue_valid),
        .issue_opa      (issue_opa),
        .issue_opb      (issue_opb),
        .issue_alu_func (issue_alu_func),
        .issue_rob_tag  (issue_rob_tag)
    );

endmodule

`default_nettype wire

//--- hdl/issue_select.sv
/*
 * priority pick of the lowest ready station entry
 * grants it and registers its payload towards the functional unit
 */
`default_nettype none

module issue_select (
    input  logic                            clock,
    input  logic                            reset,
    rs_slot_if.issue                        slots [id_pkg::rs_entries],
    output logic                            issue_valid,
    output logic [id_pkg::xlen-1:0]         issue_opa,
    output logic [id_pkg::xlen-1:0]         issue_opb,
    output id_pkg::alu_func_t               issue_alu_func,
    output logic [id_pkg::rob_tag_bits-1:0] issue_rob_tag
);

    import id_pkg::*;

    logic [rs_entries-1:0] ready_vec;
    logic [rs_entries-1:0] grant_vec;
    rs_payload_t           payloads [rs_entries];
    rs_payload_t           chosen;

    for (genvar i = 0; i < rs_entries; i++) begin : g_slot
        assign ready_vec[i]   = slots[i].ready;
        assign payloads[i]    = slots[i].entry_payload;
        assign slots[i].grant = grant_vec[i];
    end

    // lowest set bit wins
    assign grant_vec = ready_vec & (~ready_vec + 1'b1);

    // one-hot mux
    always_comb begin
        chosen = '0;
        for (int i = 0; i < rs_entries; i++) begin
            if (grant_vec[i]) begin
                chosen = chosen | payloads[i];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= |grant_vec;
        end
    end

    always_ff @(posedge clock) begin
        if (|grant_vec) begin
            issue_opa      <= chosen.opa.value;
            issue_opb      <= chosen.opb.value;
            issue_alu_func <= chosen.alu_func;
            issue_rob_tag  <= chosen.rob_tag;
        end
    end

    // a granted entry is free in the next cycle and cannot win again
    no_regrant: assert property (
        @(posedge clock) disable iff (reset) (grant_vec & $past(grant_vec)) == '0
    );

endmodule

`default_nettype wire

//--- hdl/rs_entry.sv
/*
 * one reservation station entry
 * holds a payload until both operands are ready and issue select grants it
 */
`default_nettype none

module rs_entry (
    input  logic           clock,
    input  logic           reset,
    rs_slot_if.entry       slot,
    input  id_pkg::cdb_t   cdb
);

    import id_pkg::*;

    logic        busy;
    rs_payload_t held;

    //////////////////////////////////////////////////
    // occupancy
    always_ff @(posedge clock) begin
        if (reset) begin
            busy <= 1'b0;
        end else if (slot.load) begin
            busy <= 1'b1;
        end else if (slot.grant) begin
            // free again from the next cycle
            busy <= 1'b0;
        end
    end

    //////////////////////////////////////////////////
    // payload capture and operand wakeup
    always_ff @(posedge clock) begin
        if (slot.load) begin
            held <= slot.payload;
        end else if (busy) begin
            held.opa <= operand_wakeup(held.opa, cdb);
            held.opb <= operand_wakeup(held.opb, cdb);
        end
    end

    assign slot.busy          = busy;
    assign slot.ready         = busy && held.opa.ready && held.opb.ready;
    assign slot.entry_payload = held;

    // dispatch only targets free entries
    no_load_while_busy: assert property (
        @(posedge clock) disable iff (reset) slot.load |-> !busy
    );

    // issue select only grants entries that have both operands
    no_grant_unless_ready: assert property (
        @(posedge clock) disable iff (reset) slot.grant |-> slot.ready
    );

endmodule

`default_nettype wire

//--- hdl/rs_slot_if.sv
/*
 * one reservation station slot as seen by dispatch, the entry itself and issue select
 * instantiated as an array, one per entry
 */
`default_nettype none

interface rs_slot_if;

    import id_pkg::*;

    // dispatch side
    logic        load;
    rs_payload_t payload;

    // entry state
    logic        busy;
    logic        ready;
    rs_payload_t entry_payload;

    // issue side
    logic        grant;

    modport disp (
        output load,
        output payload,
        input  busy
    );

    modport entry (
        input  load,
        input  payload,
        input  grant,
        output busy,
        output ready,
        output entry_payload
    );

    modport issue (
        input  ready,
        input  entry_payload,
        output grant
    );

endinterface

`default_nettype wire
